// ==== logic/gb_cpu_defines.svh ====
`ifndef GB_CPU_DEFINES_SVH
`define GB_CPU_DEFINES_SVH

// bus widths.
`define GB_ADDR_W 16
`define GB_DATA_W 8

// first opcode fetch after reset.
`define GB_RESET_PC 16'h0000

// clocks in one machine cycle.
`define GB_MCYCLE_CLKS 4

// flag positions in the full F byte.
`define GB_FLAG_Z 7
`define GB_FLAG_N 6
`define GB_FLAG_H 5
// carry is the lowest flag bit.
`define GB_FLAG_C 4

`endif

// ==== logic/gb_cpu_pkg.sv ====
`default_nettype none

`include "gb_cpu_defines.svh"

package gb_cpu_pkg;

	// one data byte.
	typedef logic [`GB_DATA_W-1:0] byte_t;

	// bus address, also a register pair.
	typedef logic [`GB_ADDR_W-1:0] addr_t;

	// upper nibble of F, ordered Z N H C.
	typedef logic [3:0] flags_t;

	// register code of the opcode, 6 selects (HL).
	typedef logic [2:0] reg_idx_t;

	// pair code: BC DE HL SP.
	typedef logic [1:0] pair_idx_t;

	// decode state, one value per kind of machine cycle.
	typedef enum logic [2:0] {
		ph_ifetch,
		ph_cb_ifetch,
		ph_imml_fetch,
		ph_immh_fetch,
		ph_indirect_fetch,
		ph_indirect_store,
		ph_jump_imm
	} bus_phase_e;

	// source of the register write.
	typedef enum logic [2:0] {
		wb_arg,
		wb_alu,
		wb_bit,
		wb_imml,
		wb_imm16
	} wb_src_e;

endpackage

`default_nettype wire

// ==== logic/gb_cpu_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// register view shared by decode and execute.
interface regs_if;
	import gb_cpu_pkg::*;

	byte_t a;
	flags_t f;
	// selected source operand.
	byte_t arg;
	addr_t bc;
	addr_t de;
	addr_t hl;
	reg_idx_t src_idx;

	// register file side.
	modport owner (output a, f, arg, bc, de, hl, input src_idx);

	// decode and execute side.
	modport user (input a, f, arg, bc, de, hl, output src_idx);
endinterface

// opcode to the ALU, results back.
interface alu_if;
	import gb_cpu_pkg::*;

	byte_t op;
	byte_t alu_result;
	flags_t alu_flags;
	// RES/SET value.
	byte_t bit_result;
	// BIT test outcome.
	logic bit_zero;

	// decode side.
	modport issuer (output op, input alu_result, alu_flags, bit_result, bit_zero);

	// execute side.
	modport unit (input op, output alu_result, alu_flags, bit_result, bit_zero);
endinterface

`default_nettype wire

// ==== logic/gb_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gb_cpu_defines.svh"

module gb_execute (
	regs_if.user regs,
	alu_if.unit  alu
);
	import gb_cpu_pkg::*;

	localparam int c_bit = `GB_FLAG_C - (`GB_DATA_W - 4);

	// carry out in the top bit.
	logic [`GB_DATA_W:0] wide;
	logic cy_use;
	byte_t res;
	logic fn, fh, fcy;
	byte_t bit_val;

	always_comb begin
		cy_use = 1'b0;
		wide = '0;
		res = '0;
		fn = 1'b0;
		fh = 1'b0;
		fcy = 1'b0;
		case (alu.op[5:3])
			// ADD, ADC.
			3'd0, 3'd1: begin
				cy_use = alu.op[3] & regs.f[c_bit];
				wide = {1'b0, regs.a} + {1'b0, regs.arg} + {{`GB_DATA_W{1'b0}}, cy_use};
				res = wide[`GB_DATA_W-1:0];
				fcy = wide[`GB_DATA_W];
				fh = ((regs.a[4] == regs.arg[4]) == res[4]);
			end
			// SUB, SBC, CP; CP takes no carry.
			3'd2, 3'd3, 3'd7: begin
				cy_use = alu.op[3] & !alu.op[5] & regs.f[c_bit];
				wide = {1'b0, regs.a} - {1'b0, regs.arg} - {{`GB_DATA_W{1'b0}}, cy_use};
				res = wide[`GB_DATA_W-1:0];
				fcy = wide[`GB_DATA_W];
				fn = 1'b1;
				fh = ((res[4] == regs.arg[4]) == regs.a[4]);
			end
			3'd4: begin
				res = regs.a & regs.arg;
				// AND always sets H.
				fh = 1'b1;
			end
			3'd5:
				res = regs.a ^ regs.arg;
			default:
				res = regs.a | regs.arg;
		endcase
	end

	assign alu.alu_result = res;
	assign alu.alu_flags = {res == '0, fn, fh, fcy};

	// op[5:3] bit index, op[6] new value.
	always_comb begin
		bit_val = regs.arg;
		bit_val[alu.op[5:3]] = alu.op[6];
	end

	assign alu.bit_result = bit_val;
	assign alu.bit_zero = !regs.arg[alu.op[5:3]];

endmodule

`default_nettype wire

// ==== logic/gb_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gb_cpu_defines.svh"

module gb_result (
	input  logic                  clk,
	input  logic                  reset,
	regs_if.owner                 regs,
	alu_if.unit                   alu,
	input  logic                  reg_we,
	input  logic                  pair_we,
	input  logic                  flag_we,
	input  gb_cpu_pkg::reg_idx_t  reg_dst,
	input  gb_cpu_pkg::pair_idx_t pair_dst,
	input  gb_cpu_pkg::wb_src_e   wb_src,
	input  gb_cpu_pkg::flags_t    flag_mask,
	input  gb_cpu_pkg::byte_t     imml,
	input  gb_cpu_pkg::addr_t     imm16
);
	import gb_cpu_pkg::*;

	localparam int flag_lsb = `GB_DATA_W - 4;

	byte_t b, c, d, e, h, l, a;
	flags_t f;
	addr_t sp;
	byte_t wr_byte;
	byte_t arg;
	flags_t flag_val;

	// source operand, code 6 is the fetched byte.
	always_comb begin
		case (regs.src_idx)
			3'd0: arg = b;
			3'd1: arg = c;
			3'd2: arg = d;
			3'd3: arg = e;
			3'd4: arg = h;
			3'd5: arg = l;
			3'd6: arg = imml;
			default: arg = a;
		endcase
	end

	// 8-bit write value.
	always_comb begin
		case (wb_src)
			wb_alu: wr_byte = alu.alu_result;
			wb_bit: wr_byte = alu.bit_result;
			wb_imml: wr_byte = imml;
			wb_imm16: wr_byte = imm16[`GB_DATA_W-1:0];
			default: wr_byte = arg;
		endcase
	end

	// BIT gives Z, clears N, sets H.
	always_comb begin
		flag_val = alu.alu_flags;
		if (wb_src == wb_bit) begin
			flag_val[`GB_FLAG_Z - flag_lsb] = alu.bit_zero;
			flag_val[`GB_FLAG_N - flag_lsb] = 1'b0;
			flag_val[`GB_FLAG_H - flag_lsb] = 1'b1;
			flag_val[`GB_FLAG_C - flag_lsb] = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reg_we) begin
			case (reg_dst)
				3'd0: b <= wr_byte;
				3'd1: c <= wr_byte;
				3'd2: d <= wr_byte;
				3'd3: e <= wr_byte;
				3'd4: h <= wr_byte;
				3'd5: l <= wr_byte;
				3'd7: a <= wr_byte;
				default: ;
			endcase
		end
		// pairs always load the 16-bit value.
		if (pair_we) begin
			case (pair_dst)
				2'd0: {b, c} <= imm16;
				2'd1: {d, e} <= imm16;
				2'd2: {h, l} <= imm16;
				default: sp <= imm16;
			endcase
		end
	end

	// only masked flags change.
	always_ff @(posedge clk) begin
		if (reset)
			f <= '0;
		else if (flag_we)
			f <= (f & ~flag_mask) | (flag_val & flag_mask);
	end

	assign regs.a = a;
	assign regs.f = f;
	assign regs.arg = arg;
	assign regs.bc = {b, c};
	assign regs.de = {d, e};
	assign regs.hl = {h, l};

endmodule

`default_nettype wire

// ==== logic/gb_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gb_cpu_defines.svh"

module gb_decode (
	input  logic                  clk,
	input  logic                  reset,
	input  gb_cpu_pkg::byte_t     data,
	output gb_cpu_pkg::addr_t     adr,
	output gb_cpu_pkg::byte_t     dout,
	output logic                  ddrv,
	output logic                  read,
	output logic                  write,
	output gb_cpu_pkg::byte_t     dbg,
	regs_if.user                  regs,
	alu_if.issuer                 alu,
	output logic                  reg_we,
	output logic                  pair_we,
	output logic                  flag_we,
	output gb_cpu_pkg::reg_idx_t  reg_dst,
	output gb_cpu_pkg::pair_idx_t pair_dst,
	output gb_cpu_pkg::wb_src_e   wb_src,
	output gb_cpu_pkg::flags_t    flag_mask,
	output gb_cpu_pkg::byte_t     imml,
	output gb_cpu_pkg::addr_t     imm16
);
	import gb_cpu_pkg::*;

	localparam int cyc_w = $clog2(`GB_MCYCLE_CLKS);
	localparam int flag_lsb = `GB_DATA_W - 4;

	bus_phase_e phase, phase_n;
	logic [cyc_w-1:0] cycle, cycle_n;
	logic dummy, dummy_n;
	byte_t op, op_n;
	logic op_bank, op_bank_n;
	byte_t imml_n, immh, immh_n;
	addr_t pc, pc_n;
	addr_t adr_n;
	byte_t dout_n;
	logic ddrv_n, read_n, write_n;
	// shared incrementer for pc and HL.
	addr_t step_base, step_delta, sum16;
	logic hl_step, cond_flag, jump_taken;

	assign dbg = op;
	assign alu.op = op;
	assign regs.src_idx = op[2:0];

	// post increment/decrement loads through HL.
	assign hl_step = !op_bank && (op == 8'h22 || op == 8'h32 || op == 8'h2a || op == 8'h3a);

	// pc in the data clock, HL otherwise.
	assign step_base = (cycle == cyc_w'(1)) ? pc : regs.hl;
	assign step_delta = (cycle != cyc_w'(1) && hl_step && op[4]) ? 16'hffff : 16'h0001;
	assign sum16 = step_base + step_delta;

	assign imm16 = hl_step ? sum16 : {immh, imml};

	// op[4] picks C over Z, op[3] the wanted level.
	assign cond_flag = op[4] ? regs.f[`GB_FLAG_C - flag_lsb] : regs.f[`GB_FLAG_Z - flag_lsb];
	assign jump_taken = op[0] || (cond_flag == op[3]);

	always_comb begin
		adr_n = adr;
		read_n = read;
		write_n = write;
		ddrv_n = ddrv;
		dout_n = dout;
		phase_n = phase;
		cycle_n = cycle + cyc_w'(1);
		dummy_n = dummy;
		op_n = op;
		op_bank_n = op_bank;
		imml_n = imml;
		immh_n = immh;
		pc_n = pc;
		reg_we = 1'b0;
		reg_dst = op[5:3];
		pair_we = 1'b0;
		pair_dst = op[5:4];
		wb_src = wb_arg;
		flag_we = 1'b0;
		flag_mask = '0;

		if (dummy) begin
			// idle until the machine cycle ends.
			if (cycle == cyc_w'(`GB_MCYCLE_CLKS - 1))
				dummy_n = 1'b0;
		end else begin
			case (phase)
				ph_ifetch, ph_cb_ifetch, ph_imml_fetch, ph_immh_fetch: begin
					if (cycle == cyc_w'(0)) begin
						// read at pc.
						adr_n = pc;
						read_n = 1'b1;
						ddrv_n = 1'b0;
						if (phase == ph_ifetch || phase == ph_cb_ifetch)
							op_bank_n = (phase == ph_cb_ifetch);
					end else if (cycle == cyc_w'(1)) begin
						read_n = 1'b0;
						pc_n = sum16;
						case (phase)
							ph_imml_fetch: imml_n = data;
							ph_immh_fetch: immh_n = data;
							default: op_n = data;
						endcase
					end
				end
				ph_indirect_fetch: begin
					// adr was set by the writeback before.
					if (cycle == cyc_w'(0)) begin
						read_n = 1'b1;
						ddrv_n = 1'b0;
					end else if (cycle == cyc_w'(1)) begin
						imml_n = data;
						read_n = 1'b0;
					end
				end
				ph_indirect_store: begin
					if (cycle == cyc_w'(0)) begin
						write_n = 1'b1;
						dout_n = imml;
						ddrv_n = 1'b1;
					end else if (cycle == cyc_w'(1)) begin
						write_n = 1'b0;
					end
				end
				default: ;
			endcase

			if (cycle >= cyc_w'(2)) begin
				// writeback, then dummy clocks.
				dummy_n = 1'b1;
				phase_n = ph_ifetch;
				adr_n = regs.hl;
				casez ({op_bank, op})
					// NOP, STOP, HALT, DI, EI.
					9'h000, 9'h010, 9'h076, 9'h0f3, 9'h0fb: ;
					9'h0cb:
						phase_n = ph_cb_ifetch;
					// LD r,d8 and LD r,r'.
					9'h006, 9'h016, 9'h026, 9'h036, 9'h00e, 9'h01e, 9'h02e, 9'h03e,
					9'b0_01??_????: begin
						if (phase == ph_ifetch && op[2:0] == 3'd6)
							phase_n = op[6] ? ph_indirect_fetch : ph_imml_fetch;
						else if (op[5:3] != 3'd6)
							reg_we = 1'b1;
						else if (phase != ph_indirect_store) begin
							imml_n = regs.arg;
							phase_n = ph_indirect_store;
						end
					end
					// LD rr,d16.
					9'h001, 9'h011, 9'h021, 9'h031: begin
						case (phase)
							ph_ifetch: phase_n = ph_imml_fetch;
							ph_imml_fetch: phase_n = ph_immh_fetch;
							ph_immh_fetch: begin
								pair_we = 1'b1;
								wb_src = wb_imm16;
							end
							default: ;
						endcase
					end
					// LD (BC)/(DE),A.
					9'h002, 9'h012: begin
						if (phase == ph_ifetch) begin
							adr_n = op[4] ? regs.de : regs.bc;
							imml_n = regs.a;
							phase_n = ph_indirect_store;
						end
					end
					// LD (HL+)/(HL-),A, store at the old HL.
					9'h022, 9'h032: begin
						if (phase == ph_ifetch) begin
							imml_n = regs.a;
							phase_n = ph_indirect_store;
							pair_we = 1'b1;
							pair_dst = 2'd2;
							wb_src = wb_imm16;
						end
					end
					// LD A,(BC)/(DE).
					9'h00a, 9'h01a: begin
						if (phase == ph_ifetch) begin
							adr_n = op[4] ? regs.de : regs.bc;
							phase_n = ph_indirect_fetch;
						end else begin
							reg_we = 1'b1;
							reg_dst = 3'd7;
							wb_src = wb_imml;
						end
					end
					// LD A,(HL+)/(HL-).
					9'h02a, 9'h03a: begin
						if (phase == ph_ifetch) begin
							phase_n = ph_indirect_fetch;
							pair_we = 1'b1;
							pair_dst = 2'd2;
							wb_src = wb_imm16;
						end else begin
							reg_we = 1'b1;
							reg_dst = 3'd7;
							wb_src = wb_imml;
						end
					end
					// ALU on register, (HL) or d8.
					9'b0_10??_????, 9'b0_11??_?110: begin
						if (phase == ph_ifetch && op[2:0] == 3'd6)
							phase_n = op[6] ? ph_imml_fetch : ph_indirect_fetch;
						else begin
							// CP only touches the flags.
							reg_we = (op[5:3] != 3'd7);
							reg_dst = 3'd7;
							wb_src = wb_alu;
							flag_we = 1'b1;
							flag_mask = '1;
						end
					end
					// JP a16 and JP cc,a16.
					9'h0c3, 9'h0c2, 9'h0d2, 9'h0ca, 9'h0da: begin
						case (phase)
							ph_ifetch: phase_n = ph_imml_fetch;
							ph_imml_fetch: phase_n = ph_immh_fetch;
							ph_immh_fetch: begin
								if (jump_taken)
									phase_n = ph_jump_imm;
							end
							ph_jump_imm: pc_n = {immh, imml};
							default: ;
						endcase
					end
					// BIT n, flags only.
					9'b1_01??_????: begin
						if (phase == ph_cb_ifetch && op[2:0] == 3'd6)
							phase_n = ph_indirect_fetch;
						else begin
							wb_src = wb_bit;
							flag_we = 1'b1;
							flag_mask = 4'b1110;
						end
					end
					// RES n and SET n.
					9'b1_1???_????: begin
						if (phase == ph_cb_ifetch && op[2:0] == 3'd6)
							phase_n = ph_indirect_fetch;
						else if (op[2:0] != 3'd6) begin
							reg_we = 1'b1;
							reg_dst = op[2:0];
							wb_src = wb_bit;
						end else if (phase != ph_indirect_store) begin
							imml_n = alu.bit_result;
							phase_n = ph_indirect_store;
						end
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= ph_ifetch;
			cycle <= '0;
			dummy <= 1'b0;
			op_bank <= 1'b0;
			read <= 1'b0;
			write <= 1'b0;
			ddrv <= 1'b0;
			dout <= '0;
			pc <= `GB_RESET_PC;
		end else begin
			phase <= phase_n;
			cycle <= cycle_n;
			dummy <= dummy_n;
			op_bank <= op_bank_n;
			read <= read_n;
			write <= write_n;
			ddrv <= ddrv_n;
			dout <= dout_n;
			pc <= pc_n;
		end
	end

	// bus address and latches.
	always_ff @(posedge clk) begin
		adr <= adr_n;
		op <= op_n;
		imml <= imml_n;
		immh <= immh_n;
	end

endmodule

`default_nettype wire

// ==== logic/gb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_cpu (
	input  logic              clk,
	input  logic              reset,
	input  gb_cpu_pkg::byte_t data,
	output gb_cpu_pkg::addr_t adr,
	output gb_cpu_pkg::byte_t dout,
	output logic              ddrv,
	output logic              read,
	output logic              write,
	output gb_cpu_pkg::byte_t dbg
);
	import gb_cpu_pkg::*;

	// writeback command from decode.
	logic reg_we, pair_we, flag_we;
	reg_idx_t reg_dst;
	pair_idx_t pair_dst;
	wb_src_e wb_src;
	flags_t flag_mask;
	byte_t imml;
	addr_t imm16;

	regs_if regs ();
	alu_if alu ();

	// state machine, pc and bus.
	gb_decode i_gb_decode (
		.clk       (clk),
		.reset     (reset),
		.data      (data),
		.adr       (adr),
		.dout      (dout),
		.ddrv      (ddrv),
		.read      (read),
		.write     (write),
		.dbg       (dbg),
		.regs      (regs.user),
		.alu       (alu.issuer),
		.reg_we    (reg_we),
		.pair_we   (pair_we),
		.flag_we   (flag_we),
		.reg_dst   (reg_dst),
		.pair_dst  (pair_dst),
		.wb_src    (wb_src),
		.flag_mask (flag_mask),
		.imml      (imml),
		.imm16     (imm16)
	);

	// combinational ALU and bit unit.
	gb_execute i_gb_execute (
		.regs (regs.user),
		.alu  (alu.unit)
	);

	// register file and flags.
	gb_result i_gb_result (
		.clk       (clk),
		.reset     (reset),
		.regs      (regs.owner),
		.alu       (alu.unit),
		.reg_we    (reg_we),
		.pair_we   (pair_we),
		.flag_we   (flag_we),
		.reg_dst   (reg_dst),
		.pair_dst  (pair_dst),
		.wb_src    (wb_src),
		.flag_mask (flag_mask),
		.imml      (imml),
		.imm16     (imm16)
	);

endmodule

`default_nettype wire

// ==== verif/gb_cpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// bus strobe rules of the core.
module gb_cpu_checker (
	input logic clk,
	input logic reset,
	input logic read,
	input logic write,
	input logic ddrv
);

	// failed assertions so far.
	int unsigned assert_fails = 0;

	// one bus direction at a time.
	a_no_overlap: assert property (@(posedge clk) disable iff (reset) !(read && write))
		else begin
			assert_fails++;
			$error("read and write high in the same clock");
		end

	// data bus driven during a write.
	a_write_drives: assert property (@(posedge clk) disable iff (reset) write |-> ddrv)
		else begin
			assert_fails++;
			$error("write high while ddrv is low");
		end

	// read strobe is a single clock.
	a_read_width: assert property (@(posedge clk) disable iff (reset) $rose(read) |=> !read)
		else begin
			assert_fails++;
			$error("read strobe longer than one clock");
		end

	// write strobe is a single clock.
	a_write_width: assert property (@(posedge clk) disable iff (reset) $rose(write) |=> !write)
		else begin
			assert_fails++;
			$error("write strobe longer than one clock");
		end

	// quiet bus at the release edge and the first read one clock later.
	a_reset_quiet: assert property (@(posedge clk)
		$fell(reset) |-> !(read || write) ##1 (read && !write))
		else begin
			assert_fails++;
			$error("bus strobe too early or first read missing after reset");
		end

endmodule

`default_nettype wire

// ==== verif/gb_cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gb_cpu_defines.svh"

module gb_cpu_tb;
	import gb_cpu_pkg::*;

	localparam int max_tests = 40;
	localparam int max_len = 32;
	localparam int reset_clks = 3;

	logic clk;
	logic reset;
	byte_t data;
	addr_t adr;
	byte_t dout;
	logic ddrv;
	logic read;
	logic write;
	byte_t dbg;

	// 64 KB of memory.
	byte_t mem [0:65535];

	// test table of programs and expected stores.
	byte_t prog [max_tests][max_len];
	int prog_len [max_tests];
	addr_t exp_addr [max_tests];
	byte_t exp_byte [max_tests];
	byte_t exp_op [max_tests];
	string test_name [max_tests];
	int n_built;
	addr_t cur_dest;

	int errors;
	int failed_tests;
	bit test_ok;
	int unsigned clk_count = 0;
	int unsigned clk_limit = 0;

	gb_cpu i_gb_cpu (
		.clk   (clk),
		.reset (reset),
		.data  (data),
		.adr   (adr),
		.dout  (dout),
		.ddrv  (ddrv),
		.read  (read),
		.write (write),
		.dbg   (dbg)
	);

	bind gb_cpu gb_cpu_checker i_gb_cpu_checker (
		.clk   (clk),
		.reset (reset),
		.read  (read),
		.write (write),
		.ddrv  (ddrv)
	);

	// asynchronous read while the strobe is high.
	assign data = read ? mem[adr] : '0;

	always @(posedge clk) begin
		if (write)
			mem[adr] <= dout;
	end

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// run limit from the program lengths.
	always @(posedge clk) begin
		clk_count <= clk_count + 1;
		if (clk_limit != 0 && clk_count >= clk_limit) begin
			$display("timeout after %0d clocks, result store never seen", clk_count);
			$display("Test failed");
			$finish;
		end
	end

	// background pattern over every address bit.
	function automatic byte_t fill_byte(addr_t a);
		return a[7:0] ^ a[15:8] ^ 8'h5a;
	endfunction

	// result and Z N H C from the flag rules.
	function automatic logic [11:0] alu_model(logic [2:0] kind, byte_t x, byte_t y, logic cin);
		int full;
		int half;
		logic cy;
		logic n;
		logic h;
		logic c;
		byte_t r;
		n = 1'b0;
		h = 1'b0;
		c = 1'b0;
		half = 0;
		// only ADC and SBC take the carry.
		cy = (kind == 3'd1 || kind == 3'd3) ? cin : 1'b0;
		case (kind)
			3'd0, 3'd1: begin
				full = int'(x) + int'(y) + int'(cy);
				half = int'(x[3:0]) + int'(y[3:0]) + int'(cy);
				h = (half > 15);
				c = (full > 255);
			end
			3'd2, 3'd3, 3'd7: begin
				full = int'(x) - int'(y) - int'(cy);
				half = int'(x[3:0]) - int'(y[3:0]) - int'(cy);
				n = 1'b1;
				h = (half < 0);
				c = (full < 0);
			end
			3'd4: begin
				full = int'(x & y);
				h = 1'b1;
			end
			3'd5:
				full = int'(x ^ y);
			default:
				full = int'(x | y);
		endcase
		r = byte_t'(full);
		return {r, r == 8'h00, n, h, c};
	endfunction

	function automatic string alu_name(logic [2:0] kind);
		case (kind)
			3'd0: return "add";
			3'd1: return "adc";
			3'd2: return "sub";
			3'd3: return "sbc";
			3'd4: return "and";
			3'd5: return "xor";
			3'd6: return "or";
			default: return "cp";
		endcase
	endfunction

	// fl holds Z N H C with Z on top.
	function automatic bit branch_taken(byte_t jp_op, flags_t fl);
		case (jp_op)
			8'hc2: return !fl[3];
			8'hca: return fl[3];
			8'hd2: return !fl[0];
			default: return fl[0];
		endcase
	endfunction

	task automatic put_byte(byte_t b);
		prog[n_built][prog_len[n_built]] = b;
		prog_len[n_built]++;
	endtask

	task automatic put_word(addr_t w);
		put_byte(w[7:0]);
		put_byte(w[15:8]);
	endtask

	// LD r,d8.
	task automatic load_reg8(reg_idx_t r, byte_t v);
		put_byte({2'b00, r, 3'b110});
		put_byte(v);
	endtask

	// LD rr,d16.
	task automatic load_pair(pair_idx_t p, addr_t w);
		put_byte({2'b00, p, 4'b0001});
		put_word(w);
	endtask

	// LD HL,a16 then LD (HL),A.
	task automatic store_a_at(addr_t a);
		load_pair(2'd2, a);
		put_byte(8'h77);
	endtask

	task automatic cb_op(byte_t op);
		put_byte(8'hcb);
		put_byte(op);
	endtask

	// JP to itself.
	task automatic park_loop();
		addr_t here;
		here = addr_t'(`GB_RESET_PC + prog_len[n_built]);
		put_byte(8'hc3);
		put_word(here);
	endtask

	// JP cc where each path stores its own marker at HL.
	task automatic branch_on(byte_t jp_op, byte_t mark_nt, byte_t mark_t);
		addr_t target;
		// skip the jump and the 6 byte not taken path.
		target = addr_t'(`GB_RESET_PC + prog_len[n_built] + 9);
		put_byte(jp_op);
		put_word(target);
		load_reg8(3'd7, mark_nt);
		put_byte(8'h77);
		park_loop();
		load_reg8(3'd7, mark_t);
		put_byte(8'h77);
	endtask

	task automatic begin_program(string name);
		test_name[n_built] = name;
		prog_len[n_built] = 0;
		cur_dest = addr_t'(16'hc000 + 4 * n_built);
	endtask

	task automatic end_program(addr_t a, byte_t b);
		// the storing instruction is the last one before the park loop.
		exp_op[n_built] = prog[n_built][prog_len[n_built] - 1];
		park_loop();
		exp_addr[n_built] = a;
		exp_byte[n_built] = b;
		n_built++;
	endtask

	task automatic build_tests();
		byte_t x;
		byte_t y;
		byte_t c0;
		byte_t c1;
		byte_t v;
		byte_t mask;
		logic [2:0] bsel;
		logic [11:0] model;
		byte_t br_op [6];
		byte_t br_x [6];
		byte_t br_y [6];
		n_built = 0;

		// LD r,d8 then LD r,r' then LD (BC),A.
		begin_program("ld r,d8 ld r,r' ld (bc),a");
		load_reg8(3'd0, 8'hc0);
		load_reg8(3'd1, 8'h12);
		load_reg8(3'd3, 8'h3c);
		put_byte(8'h63);
		put_byte(8'h7c);
		put_byte(8'h02);
		end_program(16'hc012, 8'h3c);

		begin_program("ld a,(de) ld (bc),a");
		load_pair(2'd1, 16'hc055);
		put_byte(8'h1a);
		load_pair(2'd0, 16'hc066);
		put_byte(8'h02);
		end_program(16'hc066, fill_byte(16'hc055));

		// store lands one above the loaded byte.
		begin_program("ld a,(hl+) ld (hl-),a");
		load_pair(2'd2, 16'hc020);
		put_byte(8'h2a);
		put_byte(8'h32);
		end_program(16'hc021, fill_byte(16'hc020));

		begin_program("ld a,(hl-) ld (hl+),a");
		load_pair(2'd2, 16'hc041);
		put_byte(8'h3a);
		put_byte(8'h22);
		end_program(16'hc040, fill_byte(16'hc041));

		// ALU with random operands and the carry preset by CP c0,c1.
		for (int k = 0; k < 7; k++) begin
			for (int s = 0; s < 2; s++) begin
				x = byte_t'($urandom);
				y = byte_t'($urandom);
				c0 = byte_t'($urandom);
				c1 = byte_t'($urandom);
				model = alu_model(3'(k), x, y, c0 < c1);
				begin_program($sformatf("alu %s %s", alu_name(3'(k)), s ? "d8" : "reg"));
				load_reg8(3'd7, c0);
				put_byte(8'hfe);
				put_byte(c1);
				load_reg8(3'd7, x);
				if (s == 0) begin
					load_reg8(3'd2, y);
					put_byte({2'b10, 3'(k), 3'd2});
				end else begin
					put_byte({2'b11, 3'(k), 3'b110});
					put_byte(y);
				end
				store_a_at(cur_dest);
				end_program(cur_dest, model[11:4]);
			end
		end

		// CP keeps A.
		x = byte_t'($urandom);
		y = byte_t'($urandom);
		begin_program("cp d8 keeps a");
		load_reg8(3'd7, x);
		put_byte(8'hfe);
		put_byte(y);
		store_a_at(cur_dest);
		end_program(cur_dest, x);

		begin_program("cp reg keeps a");
		load_reg8(3'd0, y);
		load_reg8(3'd7, x);
		put_byte(8'hb8);
		store_a_at(cur_dest);
		end_program(cur_dest, x);

		// conditional jumps after CP.
		br_op = '{8'hca, 8'hc2, 8'hda, 8'hda, 8'hd2, 8'hc2};
		br_x = '{8'h05, 8'h05, 8'h03, 8'h09, 8'h09, 8'h09};
		br_y = '{8'h05, 8'h05, 8'h07, 8'h07, 8'h07, 8'h07};
		for (int j = 0; j < 6; j++) begin
			model = alu_model(3'd7, br_x[j], br_y[j], 1'b0);
			begin_program($sformatf("jp %h after cp %h,%h", br_op[j], br_x[j], br_y[j]));
			load_pair(2'd2, cur_dest);
			load_reg8(3'd7, br_x[j]);
			put_byte(8'hfe);
			put_byte(br_y[j]);
			branch_on(br_op[j], 8'h4e, 8'hb7);
			end_program(cur_dest, branch_taken(br_op[j], model[3:0]) ? 8'hb7 : 8'h4e);
		end

		// SET and RES on registers.
		v = byte_t'($urandom);
		bsel = 3'($urandom);
		mask = byte_t'(1) << bsel;
		begin_program("set b,d");
		load_reg8(3'd2, v);
		cb_op({2'b11, bsel, 3'd2});
		put_byte(8'h7a);
		store_a_at(cur_dest);
		end_program(cur_dest, v | mask);

		begin_program("res b,e");
		load_reg8(3'd3, v);
		cb_op({2'b10, bsel, 3'd3});
		put_byte(8'h7b);
		store_a_at(cur_dest);
		end_program(cur_dest, v & ~mask);

		// read-modify-write of the background byte.
		begin_program("set b,(hl)");
		load_pair(2'd2, cur_dest);
		cb_op({2'b11, bsel, 3'd6});
		end_program(cur_dest, fill_byte(cur_dest) | mask);

		bsel = 3'($urandom);
		mask = byte_t'(1) << bsel;
		begin_program("res b,(hl)");
		load_pair(2'd2, cur_dest);
		cb_op({2'b10, bsel, 3'd6});
		end_program(cur_dest, fill_byte(cur_dest) & ~mask);

		// BIT then JP Z for a set and a clear bit.
		begin_program("bit b,c set");
		load_reg8(3'd1, v | mask);
		cb_op({2'b01, bsel, 3'd1});
		load_pair(2'd2, cur_dest);
		branch_on(8'hca, 8'h61, 8'h9e);
		end_program(cur_dest, 8'h61);

		begin_program("bit b,c clear");
		load_reg8(3'd1, v & ~mask);
		cb_op({2'b01, bsel, 3'd1});
		load_pair(2'd2, cur_dest);
		branch_on(8'hca, 8'h61, 8'h9e);
		end_program(cur_dest, 8'h9e);
	endtask

	task automatic check_addr(string name, addr_t got, addr_t expected);
		if (got !== expected) begin
			$display("FAIL %s: got %h expected %h", name, got, expected);
			errors++;
			test_ok = 1'b0;
		end
	endtask

	task automatic check_byte(string name, byte_t got, byte_t expected);
		if (got !== expected) begin
			$display("FAIL %s: got %h expected %h", name, got, expected);
			errors++;
			test_ok = 1'b0;
		end
	endtask

	task automatic run_test(int t);
		int i;
		int wait_clks;
		test_ok = 1'b1;
		@(posedge clk);
		#1;
		reset = 1'b1;
		for (i = 0; i < 65536; i++)
			mem[i] <= fill_byte(addr_t'(i));
		for (i = 0; i < prog_len[t]; i++)
			mem[addr_t'(`GB_RESET_PC + i)] <= prog[t][i];
		repeat (reset_clks) @(posedge clk);
		#1;
		reset = 1'b0;

		// first fetch after reset.
		wait_clks = 0;
		@(negedge clk);
		while (read !== 1'b1 && wait_clks < 8) begin
			@(negedge clk);
			wait_clks++;
		end
		if (read !== 1'b1) begin
			$display("test %0d: no bus read in the clocks after reset", t);
			errors++;
			test_ok = 1'b0;
		end else begin
			check_addr("adr", adr, `GB_RESET_PC);
		end

		// first store into the result page.
		while (!(write === 1'b1 && adr[15:8] == 8'hc0))
			@(negedge clk);
		check_addr("adr", adr, exp_addr[t]);
		check_byte("dout", dout, exp_byte[t]);
		check_byte("dbg", dbg, exp_op[t]);
		if (!test_ok)
			failed_tests++;
		$display("test %0d %s: %s", t, test_name[t], test_ok ? "ok" : "mismatch");
	endtask

	initial begin
		int total;
		reset = 1'b1;
		errors = 0;
		failed_tests = 0;
		void'($urandom(55447));
		build_tests();
		total = 0;
		for (int t = 0; t < n_built; t++)
			total += prog_len[t];
		// 12 machine cycles per byte plus reset and slack.
		clk_limit = total * 12 * `GB_MCYCLE_CLKS + n_built * (reset_clks + 4) + 200;

		for (int t = 0; t < n_built; t++)
			run_test(t);

		if (i_gb_cpu.i_gb_cpu_checker.assert_fails != 0) begin
			$display("%0d bus assertion failures", i_gb_cpu.i_gb_cpu_checker.assert_fails);
			errors += i_gb_cpu.i_gb_cpu_checker.assert_fails;
		end
		$display("%0d tests, %0d ok, %0d with mismatches, %0d errors",
			n_built, n_built - failed_tests, failed_tests, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/gb_cpu_pkg.sv
logic/gb_cpu_if.sv
logic/gb_execute.sv
logic/gb_result.sv
logic/gb_decode.sv
logic/gb_cpu.sv
verif/gb_cpu_checker.sv
verif/gb_cpu_tb.sv
